// ==== verilog/video_settings.svh ====
`ifndef VIDEO_SETTINGS_SVH
`define VIDEO_SETTINGS_SVH

`define TIMING_W 11 // Counter and timing constant width

// Switch codes
`define SW_VGA   4'b0000
`define SW_SVGA  4'b0001
`define SW_XGA   4'b0011
`define SW_HD720 4'b0010
`define SW_SXGA  4'b1000

//////////////////////////////////////////////////
// 640x480 at 60 Hz
`define HPIXELS_VGA  11'd640
`define HFNPRCH_VGA  11'd16
`define HSYNCPW_VGA  11'd96
`define HBKPRCH_VGA  11'd48
`define VLINES_VGA   11'd480
`define VFNPRCH_VGA  11'd11
`define VSYNCPW_VGA  11'd2
`define VBKPRCH_VGA  11'd32
`define NEG_SYNC_VGA 1'b1

// 800x600 at 60 Hz
`define HPIXELS_SVGA  11'd800
`define HFNPRCH_SVGA  11'd40
`define HSYNCPW_SVGA  11'd128
`define HBKPRCH_SVGA  11'd88
`define VLINES_SVGA   11'd600
`define VFNPRCH_SVGA  11'd1
`define VSYNCPW_SVGA  11'd4
`define VBKPRCH_SVGA  11'd23
`define NEG_SYNC_SVGA 1'b0

// 1024x768 at 60 Hz
`define HPIXELS_XGA  11'd1024
`define HFNPRCH_XGA  11'd24
`define HSYNCPW_XGA  11'd136
`define HBKPRCH_XGA  11'd160
`define VLINES_XGA   11'd768
`define VFNPRCH_XGA  11'd3
`define VSYNCPW_XGA  11'd6
`define VBKPRCH_XGA  11'd29
`define NEG_SYNC_XGA 1'b1

// 1280x720 at 60 Hz
`define HPIXELS_HD720  11'd1280
`define HFNPRCH_HD720  11'd72
`define HSYNCPW_HD720  11'd80
`define HBKPRCH_HD720  11'd216
`define VLINES_HD720   11'd720
`define VFNPRCH_HD720  11'd3
`define VSYNCPW_HD720  11'd5
`define VBKPRCH_HD720  11'd22
`define NEG_SYNC_HD720 1'b0

// 1280x1024 at 60 Hz
`define HPIXELS_SXGA  11'd1280
`define HFNPRCH_SXGA  11'd48
`define HSYNCPW_SXGA  11'd112
`define HBKPRCH_SXGA  11'd248
`define VLINES_SXGA   11'd1024
`define VFNPRCH_SXGA  11'd1
`define VSYNCPW_SXGA  11'd3
`define VBKPRCH_SXGA  11'd38
`define NEG_SYNC_SXGA 1'b0

`endif

// ==== verilog/hdmi_timing_pkg.sv ====
`default_nettype none

`include "video_settings.svh"

package hdmi_timing_pkg;

  typedef logic [`TIMING_W-1:0] coord_t; // Pixel or line index, also timing constants
  typedef logic [7:0]           color_t; // One color component
  typedef logic [3:0]           sw_code_t; // Raw switch code

  // Mode selector state
  typedef enum logic [2:0]
  {
    MODE_VGA,
    MODE_SVGA,
    MODE_XGA,
    MODE_HD720,
    MODE_SXGA
  } video_mode_t;

endpackage

`default_nettype wire

// ==== verilog/mode_select.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "video_settings.svh"

module mode_select (
  input  wire                       clk50m_bufg,
  input  wire                       serdes_rst,
  input  wire hdmi_timing_pkg::sw_code_t sw,
  output hdmi_timing_pkg::coord_t   h_active,
  output hdmi_timing_pkg::coord_t   h_sync_start,
  output hdmi_timing_pkg::coord_t   h_sync_end,
  output hdmi_timing_pkg::coord_t   h_total,
  output hdmi_timing_pkg::coord_t   v_active,
  output hdmi_timing_pkg::coord_t   v_sync_start,
  output hdmi_timing_pkg::coord_t   v_sync_end,
  output hdmi_timing_pkg::coord_t   v_total,
  output logic                      sync_negative,
  output logic                      mode_change
);

  import hdmi_timing_pkg::*;

  sw_code_t    sw_meta;                    // First synchronizer flop
  sw_code_t    sw_sync;                    // Second synchronizer flop
  video_mode_t mode;
  video_mode_t mode_next;
  coord_t      h_pix, h_fp, h_pw, h_bp;    // Table entries for mode_next
  coord_t      v_lin, v_fp, v_pw, v_bp;
  logic        neg_n;

  always_ff @(posedge clk50m_bufg or posedge serdes_rst)
  begin
    if (serdes_rst)
    begin
      sw_meta <= '0;
      sw_sync <= '0;
    end
    else
    begin
      sw_meta <= sw;
      sw_sync <= sw_meta;
    end
  end

  //////////////////////////////////////////////////
  // Switch decode and mode table
  //////////////////////////////////////////////////
  always_comb
  begin
    case (sw_sync)
      `SW_VGA:  mode_next = MODE_VGA;
      `SW_SVGA: mode_next = MODE_SVGA;
      `SW_XGA:  mode_next = MODE_XGA;
      `SW_SXGA: mode_next = MODE_SXGA;
      default:  mode_next = MODE_HD720; // 720p and all unlisted codes
    endcase
  end

  always_comb
  begin
    case (mode_next)
      MODE_VGA:
      begin
        {h_pix, h_fp, h_pw, h_bp} = {`HPIXELS_VGA, `HFNPRCH_VGA, `HSYNCPW_VGA, `HBKPRCH_VGA};
        {v_lin, v_fp, v_pw, v_bp} = {`VLINES_VGA, `VFNPRCH_VGA, `VSYNCPW_VGA, `VBKPRCH_VGA};
        neg_n = `NEG_SYNC_VGA;
      end
      MODE_SVGA:
      begin
        {h_pix, h_fp, h_pw, h_bp} = {`HPIXELS_SVGA, `HFNPRCH_SVGA, `HSYNCPW_SVGA, `HBKPRCH_SVGA};
        {v_lin, v_fp, v_pw, v_bp} = {`VLINES_SVGA, `VFNPRCH_SVGA, `VSYNCPW_SVGA, `VBKPRCH_SVGA};
        neg_n = `NEG_SYNC_SVGA;
      end
      MODE_XGA:
      begin
        {h_pix, h_fp, h_pw, h_bp} = {`HPIXELS_XGA, `HFNPRCH_XGA, `HSYNCPW_XGA, `HBKPRCH_XGA};
        {v_lin, v_fp, v_pw, v_bp} = {`VLINES_XGA, `VFNPRCH_XGA, `VSYNCPW_XGA, `VBKPRCH_XGA};
        neg_n = `NEG_SYNC_XGA;
      end
      MODE_SXGA:
      begin
        {h_pix, h_fp, h_pw, h_bp} = {`HPIXELS_SXGA, `HFNPRCH_SXGA, `HSYNCPW_SXGA, `HBKPRCH_SXGA};
        {v_lin, v_fp, v_pw, v_bp} = {`VLINES_SXGA, `VFNPRCH_SXGA, `VSYNCPW_SXGA, `VBKPRCH_SXGA};
        neg_n = `NEG_SYNC_SXGA;
      end
      default:
      begin
        {h_pix, h_fp, h_pw, h_bp} = {`HPIXELS_HD720, `HFNPRCH_HD720, `HSYNCPW_HD720,
                                     `HBKPRCH_HD720};
        {v_lin, v_fp, v_pw, v_bp} = {`VLINES_HD720, `VFNPRCH_HD720, `VSYNCPW_HD720,
                                     `VBKPRCH_HD720};
        neg_n = `NEG_SYNC_HD720;
      end
    endcase
  end

  // Constants and mode_change leave this register together
  always_ff @(posedge clk50m_bufg or posedge serdes_rst)
  begin
    if (serdes_rst)
    begin
      mode          <= MODE_HD720;
      mode_change   <= 1'b0;
      sync_negative <= `NEG_SYNC_HD720;
      h_active      <= `HPIXELS_HD720;
      h_sync_start  <= `HPIXELS_HD720 + `HFNPRCH_HD720;
      h_sync_end    <= `HPIXELS_HD720 + `HFNPRCH_HD720 + `HSYNCPW_HD720;
      h_total       <= `HPIXELS_HD720 + `HFNPRCH_HD720 + `HSYNCPW_HD720 + `HBKPRCH_HD720;
      v_active      <= `VLINES_HD720;
      v_sync_start  <= `VLINES_HD720 + `VFNPRCH_HD720;
      v_sync_end    <= `VLINES_HD720 + `VFNPRCH_HD720 + `VSYNCPW_HD720;
      v_total       <= `VLINES_HD720 + `VFNPRCH_HD720 + `VSYNCPW_HD720 + `VBKPRCH_HD720;
    end
    else
    begin
      mode          <= mode_next;
      mode_change   <= (mode_next != mode); // One cycle per state change
      sync_negative <= neg_n;
      h_active      <= h_pix;
      h_sync_start  <= h_pix + h_fp;
      h_sync_end    <= h_pix + h_fp + h_pw;
      h_total       <= h_pix + h_fp + h_pw + h_bp;
      v_active      <= v_lin;
      v_sync_start  <= v_lin + v_fp;
      v_sync_end    <= v_lin + v_fp + v_pw;
      v_total       <= v_lin + v_fp + v_pw + v_bp;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/line_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module line_timer (
  input  wire                     clk50m_bufg,
  input  wire                     serdes_rst,
  input  wire                     mode_change,
  input  wire hdmi_timing_pkg::coord_t h_active,
  input  wire hdmi_timing_pkg::coord_t h_sync_start,
  input  wire hdmi_timing_pkg::coord_t h_sync_end,
  input  wire hdmi_timing_pkg::coord_t h_total,
  output hdmi_timing_pkg::coord_t hcount,
  output logic                    h_blank,
  output logic                    h_sync_raw,
  output logic                    end_line,
  output logic                    line_wrap
);

  //////////////////////////////////////////////////
  // Pixel counter
  //////////////////////////////////////////////////
  always_ff @(posedge clk50m_bufg or posedge serdes_rst)
  begin
    if (serdes_rst)
    begin
      hcount <= '0;
    end
    else if (mode_change || line_wrap)
    begin
      hcount <= '0; // New mode or end of line
    end
    else
    begin
      hcount <= hcount + 1'b1;
    end
  end

  // Decodes straight from the count
  always_comb
  begin
    line_wrap  = (hcount == h_total - 1'b1);
    end_line   = (hcount == h_active - 1'b1); // Last active pixel
    h_blank    = (hcount >= h_active);
    h_sync_raw = (hcount >= h_sync_start) && (hcount < h_sync_end);
  end

endmodule

`default_nettype wire

// ==== verilog/frame_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module frame_timer (
  input  wire                     clk50m_bufg,
  input  wire                     serdes_rst,
  input  wire                     mode_change,
  input  wire                     line_wrap,
  input  wire hdmi_timing_pkg::coord_t v_active,
  input  wire hdmi_timing_pkg::coord_t v_sync_start,
  input  wire hdmi_timing_pkg::coord_t v_sync_end,
  input  wire hdmi_timing_pkg::coord_t v_total,
  output hdmi_timing_pkg::coord_t vcount,
  output logic                    v_blank,
  output logic                    v_sync_raw
);

  logic frame_wrap; // Last line of the frame

  //////////////////////////////////////////////////
  // Line counter
  //////////////////////////////////////////////////
  always_ff @(posedge clk50m_bufg or posedge serdes_rst)
  begin
    if (serdes_rst)
    begin
      vcount <= '0;
    end
    else if (mode_change)
    begin
      vcount <= '0;
    end
    else if (line_wrap)
    begin
      if (frame_wrap)
        vcount <= '0;
      else
        vcount <= vcount + 1'b1;
    end
  end

  always_comb
  begin
    frame_wrap = (vcount == v_total - 1'b1);
    v_blank    = (vcount >= v_active);
    v_sync_raw = (vcount >= v_sync_start) && (vcount < v_sync_end);
  end

endmodule

`default_nettype wire

// ==== verilog/sync_output.sv ====
`timescale 1ns/100ps
`default_nettype none

module sync_output (
  input  wire                     clk50m_bufg,
  input  wire                     serdes_rst,
  input  wire                     h_blank,
  input  wire                     v_blank,
  input  wire                     h_sync_raw,
  input  wire                     v_sync_raw,
  input  wire                     sync_negative,
  input  wire hdmi_timing_pkg::color_t red_in,
  input  wire hdmi_timing_pkg::color_t green_in,
  input  wire hdmi_timing_pkg::color_t blue_in,
  output logic                    retrieve_data,
  output logic                    de,
  output logic                    hsync,
  output logic                    vsync,
  output hdmi_timing_pkg::color_t red_out,
  output hdmi_timing_pkg::color_t green_out,
  output hdmi_timing_pkg::color_t blue_out
);

  logic hsync_q; // First sync stage, polarity applied
  logic vsync_q;

  //////////////////////////////////////////////////
  // Request, enable and sync pipeline
  //////////////////////////////////////////////////
  always_ff @(posedge clk50m_bufg or posedge serdes_rst)
  begin
    if (serdes_rst)
    begin
      retrieve_data <= 1'b0;
      de            <= 1'b0;
      hsync_q       <= 1'b0;
      vsync_q       <= 1'b0;
      hsync         <= 1'b0;
      vsync         <= 1'b0;
    end
    else
    begin
      retrieve_data <= !h_blank && !v_blank; // One cycle ahead of de
      de            <= retrieve_data;
      hsync_q       <= h_sync_raw ^ sync_negative;
      vsync_q       <= v_sync_raw ^ sync_negative;
      hsync         <= hsync_q;
      vsync         <= vsync_q;
    end
  end

  // Pixel sampled while retrieve_data is high shows up with de
  always_ff @(posedge clk50m_bufg)
  begin
    red_out   <= red_in;
    green_out <= green_in;
    blue_out  <= blue_in;
  end

endmodule

`default_nettype wire

// ==== verilog/hdmi_video_timing.sv ====
`timescale 1ns/100ps
`default_nettype none

module hdmi_video_timing (
  input  wire                       clk50m_bufg,
  input  wire                       serdes_rst,
  input  wire hdmi_timing_pkg::sw_code_t sw,
  input  wire hdmi_timing_pkg::color_t   red_in,
  input  wire hdmi_timing_pkg::color_t   green_in,
  input  wire hdmi_timing_pkg::color_t   blue_in,
  output wire                       retrieve_data, // Pixel request, one cycle before de
  output wire                       de,
  output wire                       hsync,
  output wire                       vsync,
  output wire                       end_line,
  output wire hdmi_timing_pkg::coord_t  y_pos,
  output wire hdmi_timing_pkg::color_t  red_out,
  output wire hdmi_timing_pkg::color_t  green_out,
  output wire hdmi_timing_pkg::color_t  blue_out
);

  import hdmi_timing_pkg::*;

  wire coord_t h_active, h_sync_start, h_sync_end, h_total;
  wire coord_t v_active, v_sync_start, v_sync_end, v_total;
  wire         sync_negative;
  wire         mode_change;
  wire         line_wrap;
  wire         h_blank, h_sync_raw;
  wire         v_blank, v_sync_raw;

  mode_select mode_select_inst (
    .clk50m_bufg   (clk50m_bufg),
    .serdes_rst    (serdes_rst),
    .sw            (sw),
    .h_active      (h_active),
    .h_sync_start  (h_sync_start),
    .h_sync_end    (h_sync_end),
    .h_total       (h_total),
    .v_active      (v_active),
    .v_sync_start  (v_sync_start),
    .v_sync_end    (v_sync_end),
    .v_total       (v_total),
    .sync_negative (sync_negative),
    .mode_change   (mode_change)
  );

  line_timer line_timer_inst (
    .clk50m_bufg  (clk50m_bufg),
    .serdes_rst   (serdes_rst),
    .mode_change  (mode_change),
    .h_active     (h_active),
    .h_sync_start (h_sync_start),
    .h_sync_end   (h_sync_end),
    .h_total      (h_total),
    .hcount       (),           // Pixel position not needed outside
    .h_blank      (h_blank),
    .h_sync_raw   (h_sync_raw),
    .end_line     (end_line),
    .line_wrap    (line_wrap)
  );

  frame_timer frame_timer_inst (
    .clk50m_bufg  (clk50m_bufg),
    .serdes_rst   (serdes_rst),
    .mode_change  (mode_change),
    .line_wrap    (line_wrap),
    .v_active     (v_active),
    .v_sync_start (v_sync_start),
    .v_sync_end   (v_sync_end),
    .v_total      (v_total),
    .vcount       (y_pos),
    .v_blank      (v_blank),
    .v_sync_raw   (v_sync_raw)
  );

  sync_output sync_output_inst (
    .clk50m_bufg   (clk50m_bufg),
    .serdes_rst    (serdes_rst),
    .h_blank       (h_blank),
    .v_blank       (v_blank),
    .h_sync_raw    (h_sync_raw),
    .v_sync_raw    (v_sync_raw),
    .sync_negative (sync_negative),
    .red_in        (red_in),
    .green_in      (green_in),
    .blue_in       (blue_in),
    .retrieve_data (retrieve_data),
    .de            (de),
    .hsync         (hsync),
    .vsync         (vsync),
    .red_out       (red_out),
    .green_out     (green_out),
    .blue_out      (blue_out)
  );

endmodule

`default_nettype wire

// ==== verification/tb_hdmi_video_timing.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_hdmi_video_timing;

  import hdmi_timing_pkg::*;

  // Expected VGA and SVGA timing as active + porch + sync + porch
  localparam int VGA_H_ACTIVE  = 640;
  localparam int VGA_H_SYNC    = 96;
  localparam int VGA_H_TOTAL   = 640 + 16 + 96 + 48;
  localparam int VGA_V_ACTIVE  = 480;
  localparam int VGA_V_SYNC    = 2;
  localparam int VGA_V_TOTAL   = 480 + 11 + 2 + 32;
  localparam logic VGA_NEG     = 1'b1;
  localparam int SVGA_H_ACTIVE = 800;
  localparam int SVGA_H_SYNC   = 128;
  localparam int SVGA_H_TOTAL  = 800 + 40 + 128 + 88;
  localparam logic SVGA_NEG    = 1'b0;
  localparam int WATCHDOG_NS   = 25_000_000; // Two VGA frames are 16.8 ms

  logic        clk50m_bufg = 1'b0;
  logic        serdes_rst;
  sw_code_t    sw;
  color_t      red_in, green_in, blue_in;
  wire         retrieve_data, de, hsync, vsync, end_line;
  wire coord_t y_pos;
  wire color_t red_out, green_out, blue_out;

  int          errors;
  int unsigned seed_val;
  logic [31:0] rnd;
  logic        pix_track;             // Record requested pixels
  logic [23:0] pix_queue[$];          // Pixels the DUT should show on de

  always #10 clk50m_bufg = ~clk50m_bufg; // 50 MHz

  hdmi_video_timing hdmi_video_timing_inst (
    .clk50m_bufg   (clk50m_bufg),
    .serdes_rst    (serdes_rst),
    .sw            (sw),
    .red_in        (red_in),
    .green_in      (green_in),
    .blue_in       (blue_in),
    .retrieve_data (retrieve_data),
    .de            (de),
    .hsync         (hsync),
    .vsync         (vsync),
    .end_line      (end_line),
    .y_pos         (y_pos),
    .red_out       (red_out),
    .green_out     (green_out),
    .blue_out      (blue_out)
  );

  //////////////////////////////////////////////////
  // Pixel source and watchdog
  //////////////////////////////////////////////////
  initial
  begin
    seed_val = $urandom(27);
    forever
    begin
      @(posedge clk50m_bufg);
      if (pix_track && retrieve_data)
        pix_queue.push_back({red_in, green_in, blue_in}); // Sampled by the DUT on this edge
      rnd = $urandom;
      red_in   <= rnd[23:16];
      green_in <= rnd[15:8];
      blue_in  <= rnd[7:0];
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before all tests finished");
    $display("FAIL: see errors above");
    $finish;
  end

  task automatic report_mismatch(input string test, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
    begin
      $display("FAIL %s %s: expected %0d, actual %0d", test, what, expected, actual);
      errors++;
    end
  endtask

  task automatic report_error(input string msg);
    begin
      $display("ERROR %s", msg);
      errors++;
    end
  endtask

  // Returns on the first sample with hsync at its active level
  task automatic wait_sync_start(input logic neg);
    logic prev;
    begin
      @(negedge clk50m_bufg);
      prev = hsync;
      @(negedge clk50m_bufg);
      while (!((hsync == ~neg) && (prev != ~neg)))
      begin
        prev = hsync;
        @(negedge clk50m_bufg);
      end
    end
  endtask

  // Checks line period, sync width, de run, end_line, alignment and pixels
  task automatic watch_lines(input string name, input int nlines, input logic neg,
                             input int exp_period, input int exp_width, input int exp_de);
    int          n, period, width, de_run, el_count, de_lines;
    logic        prev_sync, prev_rd, prev_de, prev_el, prev2_el;
    logic [23:0] exp_pix;
    begin
      wait_sync_start(neg);
      pix_track = 1'b1;
      prev_rd   = 1'b0;                   // Horizontal blanking here
      prev_de   = 1'b0;
      prev_el   = 1'b0;
      prev2_el  = 1'b0;
      de_run    = 0;
      de_lines  = 0;
      for (n = 0; n < nlines; n++)
      begin
        period   = 0;
        width    = 0;
        el_count = 0;
        do
        begin
          period++;
          if (hsync == ~neg)
            width++;
          if (end_line && !prev_el)
            el_count++;
          if (de !== prev_rd)
            report_mismatch(name, "de vs previous retrieve_data", prev_rd, de);
          if (de)
            de_run++;
          else if (prev_de)
          begin
            de_lines++;
            if (de_run != exp_de)
              report_mismatch(name, "de length", exp_de, de_run);
            de_run = 0;
          end
          if (prev_rd && !retrieve_data && !(prev2_el && !prev_el))
            report_error($sformatf("%s: end_line not 1 cycle before last request", name));
          if (de)
          begin
            if (pix_queue.size() == 0)
              report_error($sformatf("%s: de high with no pixel requested", name));
            else
            begin
              exp_pix = pix_queue.pop_front();
              if ({red_out, green_out, blue_out} !== exp_pix)
                report_mismatch(name, "pixel", exp_pix, {red_out, green_out, blue_out});
            end
          end
          prev_sync = hsync;
          prev_rd   = retrieve_data;
          prev_de   = de;
          prev2_el  = prev_el;
          prev_el   = end_line;
          @(negedge clk50m_bufg);
        end
        while (!((hsync == ~neg) && (prev_sync != ~neg)));
        if (period != exp_period)
          report_mismatch(name, "hsync period", exp_period, period);
        if (width != exp_width)
          report_mismatch(name, "hsync width", exp_width, width);
        if (el_count != 1)
          report_mismatch(name, "end_line pulses per line", 1, el_count);
      end
      if (de_lines != nlines)
        report_mismatch(name, "lines with de", nlines, de_lines);
      pix_track = 1'b0;
      if (pix_queue.size() != 0)
        report_error($sformatf("%s: requested pixels never shown on de", name));
      pix_queue.delete();
    end
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////
  task automatic reset_test;
    int i;
    begin
      for (i = 0; i <= 10; i++)
      begin
        if (i == 10)
        begin
          @(posedge clk50m_bufg);
          serdes_rst <= 1'b0;                // Last cycle checked is the first one after reset
        end
        @(negedge clk50m_bufg);
        if (retrieve_data !== 1'b0)
          report_mismatch("reset", "retrieve_data", 0, retrieve_data);
        if (de !== 1'b0)
          report_mismatch("reset", "de", 0, de);
        if (end_line !== 1'b0)
          report_mismatch("reset", "end_line", 0, end_line);
        if (y_pos !== '0)
          report_mismatch("reset", "y_pos", 0, y_pos);
      end
    end
  endtask

  task automatic vga_line_test;
    begin
      wait_sync_start(VGA_NEG);              // Settling line
      watch_lines("vga_line", 3, VGA_NEG, VGA_H_TOTAL, VGA_H_SYNC, VGA_H_ACTIVE);
    end
  endtask

  task automatic frame_test;
    int   period, low, de_lines, max_y, prev_y;
    logic prev_vs, prev_de, prev_rd, seen_zero;
    begin
      @(negedge clk50m_bufg);
      prev_vs = vsync;
      @(negedge clk50m_bufg);
      while (!(prev_vs && !vsync))
      begin
        prev_vs = vsync;
        @(negedge clk50m_bufg);
      end
      period    = 0;
      low       = 0;
      de_lines  = 0;
      max_y     = 0;
      seen_zero = 1'b0;
      prev_y    = y_pos;
      prev_de   = 1'b0;                      // Vertical blanking here
      prev_rd   = 1'b0;
      do
      begin
        period++;
        if (!vsync)
          low++;
        if (de && !prev_de)
          de_lines++;
        if (de !== prev_rd)
          report_mismatch("vga_frame", "de vs previous retrieve_data", prev_rd, de);
        if ((y_pos != prev_y) && !((y_pos == prev_y + 1) ||
            ((prev_y == VGA_V_TOTAL - 1) && (y_pos == 0))))
          report_mismatch("vga_frame", "y_pos step", (prev_y + 1) % VGA_V_TOTAL, y_pos);
        if (y_pos > max_y)
          max_y = y_pos;
        if (y_pos == 0)
          seen_zero = 1'b1;
        prev_vs = vsync;
        prev_de = de;
        prev_rd = retrieve_data;
        prev_y  = y_pos;
        @(negedge clk50m_bufg);
      end
      while (!(prev_vs && !vsync));
      if (period != VGA_V_TOTAL * VGA_H_TOTAL)
        report_mismatch("vga_frame", "vsync period", VGA_V_TOTAL * VGA_H_TOTAL, period);
      if (low != VGA_V_SYNC * VGA_H_TOTAL)
        report_mismatch("vga_frame", "vsync width", VGA_V_SYNC * VGA_H_TOTAL, low);
      if (de_lines != VGA_V_ACTIVE)
        report_mismatch("vga_frame", "lines with de", VGA_V_ACTIVE, de_lines);
      if (max_y != VGA_V_TOTAL - 1)
        report_mismatch("vga_frame", "highest y_pos", VGA_V_TOTAL - 1, max_y);
      if (!seen_zero)
        report_error("vga_frame: y_pos never returned to 0");
    end
  endtask

  task automatic svga_change_test;
    begin
      @(posedge clk50m_bufg);
      sw <= 4'b0001;
      repeat (4) @(posedge clk50m_bufg);     // Two sync flops, decode, counter clear
      @(negedge clk50m_bufg);
      if (y_pos !== '0)
        report_mismatch("svga_change", "y_pos after mode change", 0, y_pos);
      while (de)
        @(negedge clk50m_bufg);
      watch_lines("svga_line", 3, SVGA_NEG, SVGA_H_TOTAL, SVGA_H_SYNC, SVGA_H_ACTIVE);
      if (y_pos !== 11'd3)
        report_mismatch("svga_change", "y_pos after three lines", 3, y_pos);
    end
  endtask

  initial
  begin
    errors     = 0;
    pix_track  = 1'b0;
    serdes_rst = 1'b1;
    sw         = 4'b0000;                    // VGA
    red_in     = '0;
    green_in   = '0;
    blue_in    = '0;
    reset_test();
    vga_line_test();
    frame_test();
    svga_change_test();
    $display("Run complete with %0d errors", errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdmi_video_timing.f ====
+incdir+verilog
verilog/hdmi_timing_pkg.sv
verilog/mode_select.sv
verilog/line_timer.sv
verilog/frame_timer.sv
verilog/sync_output.sv
verilog/hdmi_video_timing.sv
verification/tb_hdmi_video_timing.sv

// ==== Bender.yml ====
package:
  name: hdmi_video_timing

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/hdmi_timing_pkg.sv
      - verilog/mode_select.sv
      - verilog/line_timer.sv
      - verilog/frame_timer.sv
      - verilog/sync_output.sv
      - verilog/hdmi_video_timing.sv
  - target: test
    files:
      - verification/tb_hdmi_video_timing.sv
